// File: build.f
+incdir+include
hdl/rf_pkg.sv
hdl/rf_array.sv
hdl/rf_port_ctrl.sv
hdl/rf_swt_obs.sv
hdl/rf_top.sv
tests/rf_tb.sv

// File: Bender.yml
# two-port register file with scan write-through and observation flops

package:
  name: rf_two_port

export_include_dirs:
  - include

sources:
  # design sources, package first
  - include_dirs:
      - include
    files:
      - hdl/rf_pkg.sv
      - hdl/rf_array.sv
      - hdl/rf_port_ctrl.sv
      - hdl/rf_swt_obs.sv
      - hdl/rf_top.sv

  # testbench, top module rf_tb
  - target: test
    include_dirs:
      - include
    files:
      - tests/rf_tb.sv

// File: tests/rf_tb.sv
/*
  register file testbench
  applies a table of write, read and scan rows to the two-port register file
  and checks read data, read valid and the observation flops against a model
*/

`timescale 1ns/100ps

`include "rf_settings.svh"

module rf_tb
  import rf_pkg::*;
;

  // observed pins are write enable, write address, read enable and read address
  localparam int OBS_BITS = 2 * `RF_ADDR_W + 2;

  // one table row is applied per clock
  // chk marks a read whose returned word is known and compared
  typedef struct packed {
    logic       scan;
    rf_wr_req_t wr;
    rf_rd_req_t rd;
    logic       chk;
  } row_t;

  logic       clock_b;
  logic       rst_n;
  logic       scan_mode;
  rf_wr_req_t wr_req;
  rf_rd_req_t rd_req;
  rf_data_t   rd_data;
  logic       rd_valid;
  rf_obs_t    obs_bits;

  row_t     rows[$];
  rf_data_t model [`RF_ENTRIES];
  bit       table_ready;
  logic     cur_chk;

  // expected outputs for the next rising edge
  rf_data_t exp_data;
  logic     exp_known;
  logic     exp_valid;
  rf_obs_t  exp_obs;

  int data_errors;
  int valid_errors;
  int obs_errors;

  rf_top rf_top_inst (
    .clock_b   (clock_b),
    .rst_n     (rst_n),
    .scan_mode (scan_mode),
    .wr_req    (wr_req),
    .rd_req    (rd_req),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .obs_bits  (obs_bits)
  );

  // --------------------
  // clock and watchdog
  // --------------------

  initial clock_b = 1'b0;

  always #4 clock_b = ~clock_b;

  // the limit covers the reset, every table row and some slack for draining
  initial
  begin
    wait (table_ready);
    repeat (rows.size() + 16 + 20) @(posedge clock_b);
    $display("run timed out before the stimulus table was finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  // --------------------
  // helpers
  // --------------------

  // queues one row with fresh random write data
  task automatic add_row(input logic scan, input logic wr_en, input int wr_addr,
                         input logic rd_en, input int rd_addr, input logic chk);
    row_t r;
    r.scan    = scan;
    r.wr.en   = wr_en;
    r.wr.addr = rf_addr_t'(wr_addr);
    r.wr.data = {$urandom, $urandom};
    r.rd.en   = rd_en;
    r.rd.addr = rf_addr_t'(rd_addr);
    r.chk     = chk;
    rows.push_back(r);
  endtask

  // bit j of the observed word lands in group j / 3, counted from the bottom
  function automatic rf_obs_t fold_obs(input rf_wr_req_t wr, input rf_rd_req_t rd);
    logic [OBS_BITS-1:0] pins;
    rf_obs_t folded;
    pins   = {wr.en, wr.addr, rd.en, rd.addr};
    folded = '0;
    for (int j = 0; j < OBS_BITS; j++)
    begin
      folded[j / `RF_OBS_XOR] = folded[j / `RF_OBS_XOR] ^ pins[j];
    end
    return folded;
  endfunction

  task automatic check_outputs();
    if (exp_known && rd_data !== exp_data)
    begin
      $display("[FAIL] %0t rd_data expected %h actual %h", $time, exp_data, rd_data);
      data_errors++;
    end
    if (rd_valid !== exp_valid)
    begin
      $display("[FAIL] %0t rd_valid expected %b actual %b", $time, exp_valid, rd_valid);
      valid_errors++;
    end
    if (obs_bits !== exp_obs)
    begin
      $display("[FAIL] %0t obs_bits expected %b actual %b", $time, exp_obs, obs_bits);
      obs_errors++;
    end
  endtask

  // works on the inputs the DUT samples at this edge
  // the read is taken before the write so a collision sees the old word
  task automatic predict_outputs();
    exp_valid = rd_req.en;
    if (rd_req.en)
    begin
      if (!cur_chk)
        exp_known = 1'b0;
      else if (scan_mode)
      begin
        exp_data  = wr_req.data;
        exp_known = 1'b1;
      end
      else if (rd_req.addr < `RF_ENTRIES)
      begin
        exp_data  = model[rd_req.addr];
        exp_known = 1'b1;
      end
      else
      begin
        exp_data  = '0;
        exp_known = 1'b1;
      end
    end
    if (wr_req.en && !scan_mode && wr_req.addr < `RF_ENTRIES)
      model[wr_req.addr] = wr_req.data;
  endtask

  // --------------------
  // stimulus table
  // --------------------

  task automatic build_table();
    // fill several words, including the ones that out-of-range addresses alias
    add_row(0, 1, 5, 0, 0, 0);
    add_row(0, 1, 17, 0, 0, 0);
    add_row(0, 1, 2, 0, 0, 0);
    add_row(0, 1, 36, 0, 0, 0);
    add_row(0, 1, 63, 0, 0, 0);
    add_row(0, 1, 65, 0, 0, 0);
    add_row(0, 1, 0, 0, 0, 0);
    // read back, with two idle rows where the output has to hold
    add_row(0, 0, 0, 1, 5, 1);
    add_row(0, 0, 0, 1, 17, 1);
    add_row(0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 1, 65, 1);
    add_row(0, 0, 0, 1, 0, 1);
    add_row(0, 1, 33, 1, 2, 1);
    add_row(0, 0, 0, 1, 33, 1);
    // same-address collisions return the old word, the next read the new one
    add_row(0, 1, 17, 1, 17, 1);
    add_row(0, 0, 0, 1, 17, 1);
    add_row(0, 1, 40, 0, 0, 0);
    add_row(0, 1, 40, 1, 40, 1);
    add_row(0, 1, 40, 1, 40, 1);
    add_row(0, 0, 0, 1, 40, 1);
    // out-of-range writes are dropped and out-of-range reads give zero
    add_row(0, 1, 66, 0, 0, 0);
    add_row(0, 1, 100, 0, 0, 0);
    add_row(0, 1, 127, 1, 66, 1);
    add_row(0, 0, 0, 1, 127, 1);
    add_row(0, 0, 0, 1, 2, 1);
    add_row(0, 0, 0, 1, 36, 1);
    add_row(0, 0, 0, 1, 63, 1);
    add_row(0, 1, 70, 1, 70, 1);
    // scan mode returns the write data and leaves the array alone
    add_row(1, 1, 5, 1, 5, 1);
    add_row(1, 1, 2, 1, 99, 1);
    add_row(1, 0, 0, 1, 20, 1);
    add_row(1, 1, 65, 0, 0, 0);
    add_row(0, 0, 0, 1, 5, 1);
    add_row(0, 0, 0, 1, 2, 1);
    add_row(0, 0, 0, 1, 65, 1);
    // word 10 has never been written so its value is not compared
    add_row(0, 0, 0, 1, 10, 0);
    add_row(0, 0, 0, 0, 0, 0);
    add_row(0, 1, 10, 1, 0, 1);
    add_row(0, 0, 0, 1, 10, 1);
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial
  begin
    void'($urandom(32'hf4ccdde1));
    rst_n       = 1'b0;
    scan_mode   = 1'b0;
    wr_req      = '0;
    // a read stays requested through reset so the reset values differ from normal operation
    rd_req.en   = 1'b1;
    rd_req.addr = rf_addr_t'(5);
    cur_chk     = 1'b0;
    // while in reset and right after it the outputs must all read zero
    exp_data    = '0;
    exp_known   = 1'b1;
    exp_valid   = 1'b0;
    exp_obs     = '0;
    build_table();
    table_ready = 1'b1;

    repeat (16) @(posedge clock_b);
    // the last edge of reset, every flop has been cleared in spite of the pending read
    check_outputs();
    rst_n  <= 1'b1;
    rd_req <= '0;

    // two extra edges drain the last row through the read pipeline
    for (int i = 0; i < rows.size() + 2; i++)
    begin
      @(posedge clock_b);
      check_outputs();
      predict_outputs();
      // the observation flops fold the row driven now on the coming falling edge
      if (i < rows.size())
      begin
        scan_mode <= rows[i].scan;
        wr_req    <= rows[i].wr;
        rd_req    <= rows[i].rd;
        cur_chk    = rows[i].chk;
        exp_obs    = fold_obs(rows[i].wr, rows[i].rd);
      end
      else
      begin
        scan_mode <= 1'b0;
        wr_req    <= '0;
        rd_req    <= '0;
        cur_chk    = 1'b0;
        exp_obs    = '0;
      end
    end

    $display("errors rd_data %0d rd_valid %0d obs_bits %0d", data_errors, valid_errors,
             obs_errors);
    if (data_errors + valid_errors + obs_errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: hdl/rf_top.sv
/*
  two-port register file top level
  66 by 64 array with one write and one read port, scan write-through
  and phase b observation of the array address and control inputs
*/

`timescale 1ns/100ps

`include "rf_settings.svh"

module rf_top
  import rf_pkg::*;
(
  input  logic       clock_b,
  input  logic       rst_n,
  input  logic       scan_mode,
  input  rf_wr_req_t wr_req,
  input  rf_rd_req_t rd_req,
  output rf_data_t   rd_data,
  output logic       rd_valid,
  output rf_obs_t    obs_bits
);

  // --------------------
  // internal wiring
  // --------------------

  // requests as seen by the array after scan gating
  rf_wr_req_t arr_wr;
  rf_rd_req_t arr_rd;

  // registered word coming back from the array
  rf_data_t   arr_rd_data;

  // port control handles scan gating, write-through and the output hold
  rf_port_ctrl rf_port_ctrl_inst (
    .clock_b     (clock_b),
    .rst_n       (rst_n),
    .scan_mode   (scan_mode),
    .wr_req      (wr_req),
    .rd_req      (rd_req),
    .arr_wr      (arr_wr),
    .arr_rd      (arr_rd),
    .arr_rd_data (arr_rd_data),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid)
  );

  // storage array with its own registered read
  rf_array rf_array_inst (
    .clock_b (clock_b),
    .wr      (arr_wr),
    .rd      (arr_rd),
    .rd_data (arr_rd_data)
  );

  // observed bits run from the write enable in the top bit down to the read address
  // the raw requests are observed, before any scan gating
  rf_swt_obs #(
    .OBS_PIN_NUM  (RF_OBS_PINS),
    .OBS_XOR_SIZE (`RF_OBS_XOR)
  ) rf_swt_obs_inst (
    .clock_b (clock_b),
    .rst_n   (rst_n),
    .obs_in  ({wr_req.en, wr_req.addr, rd_req.en, rd_req.addr}),
    .obs_out (obs_bits)
  );

endmodule

// File: hdl/rf_swt_obs.sv
/*
  scan write-through observation flops
  folds the array address and control bits into XOR groups and captures
  each group on the inverted clock so a scan chain can observe them
*/

`timescale 1ns/100ps

`include "rf_settings.svh"

module rf_swt_obs
  import rf_pkg::*;
#(
  parameter  int OBS_PIN_NUM  = RF_OBS_PINS,
  parameter  int OBS_XOR_SIZE = `RF_OBS_XOR,
  // one flop per full group plus one for any remainder
  localparam int OBS_FLOP_NUM = (OBS_PIN_NUM + OBS_XOR_SIZE - 1) / OBS_XOR_SIZE
)
(
  input  logic                    clock_b,
  input  logic                    rst_n,
  input  logic [OBS_PIN_NUM-1:0]  obs_in,
  output logic [OBS_FLOP_NUM-1:0] obs_out
);

  // phase b clock, made by a local inversion of the array clock
  logic clock_inv;

  logic [OBS_FLOP_NUM-1:0] obs_fold;
  logic [OBS_FLOP_NUM-1:0] obs_q;

  assign clock_inv = ~clock_b;

  // --------------------
  // XOR folding
  // --------------------

  // group i covers bits i*OBS_XOR_SIZE upward, and the last group runs to the top bit
  for (genvar i = 0; i < OBS_FLOP_NUM; i++)
  begin : g_fold
    if (i < OBS_FLOP_NUM - 1)
    begin : g_full
      assign obs_fold[i] = ^obs_in[i*OBS_XOR_SIZE +: OBS_XOR_SIZE];
    end
    else
    begin : g_last
      assign obs_fold[i] = ^obs_in[OBS_PIN_NUM-1 : i*OBS_XOR_SIZE];
    end
  end

  // --------------------
  // observation flops
  // --------------------

  // captured half a cycle after the rising edge, on the falling edge of clock_b
  always_ff @(posedge clock_inv)
  begin
    if (!rst_n)
    begin
      obs_q <= '0;
    end
    else
    begin
      obs_q <= obs_fold;
    end
  end

  assign obs_out = obs_q;

endmodule

// File: hdl/rf_port_ctrl.sv
/*
  register file port control
  gates array writes in scan mode, captures write-through data, generates the
  read valid strobe and selects and holds the returned read word
*/

`timescale 1ns/100ps

`include "rf_settings.svh"

module rf_port_ctrl
  import rf_pkg::*;
(
  input  logic       clock_b,
  input  logic       rst_n,
  input  logic       scan_mode,
  input  rf_wr_req_t wr_req,
  input  rf_rd_req_t rd_req,
  output rf_wr_req_t arr_wr,
  output rf_rd_req_t arr_rd,
  input  rf_data_t   arr_rd_data,
  output rf_data_t   rd_data,
  output logic       rd_valid
);

  // source of the word currently presented on rd_data
  // none is the state after reset and forces a zero output
  typedef enum logic [1:0] {
    SRC_NONE,
    SRC_ARRAY,
    SRC_SCAN
  } rd_src_e;

  rd_src_e  rd_src_q;
  logic     rd_valid_q;

  // write data captured for the scan write-through path
  rf_data_t swt_data_q;

  // --------------------
  // array request path
  // --------------------

  // in scan mode the array must not change, so only the enable is masked
  assign arr_wr.en   = wr_req.en & ~scan_mode;
  assign arr_wr.addr = wr_req.addr;
  assign arr_wr.data = wr_req.data;

  // reads always go to the array, the array register is simply ignored in scan mode
  assign arr_rd = rd_req;

  // --------------------
  // control state
  // --------------------

  // rd_valid follows the read enable one cycle later, one pulse per read
  // the source only moves on an accepted read so the output holds between reads
  always_ff @(posedge clock_b)
  begin
    if (!rst_n)
    begin
      rd_valid_q <= 1'b0;
      rd_src_q   <= SRC_NONE;
    end
    else
    begin
      rd_valid_q <= rd_req.en;
      if (rd_req.en)
      begin
        rd_src_q <= scan_mode ? SRC_SCAN : SRC_ARRAY;
      end
    end
  end

  // --------------------
  // write-through capture
  // --------------------

  // the write port data of the read cycle is what scan mode returns
  // addresses play no part here
  always_ff @(posedge clock_b)
  begin
    if (rd_req.en && scan_mode)
    begin
      swt_data_q <= wr_req.data;
    end
  end

  // --------------------
  // output select
  // --------------------

  always_comb
  begin
    case (rd_src_q)
      SRC_ARRAY: rd_data = arr_rd_data;
      SRC_SCAN:  rd_data = swt_data_q;
      default:   rd_data = '0;
    endcase
  end

  assign rd_valid = rd_valid_q;

endmodule

// File: hdl/rf_array.sv
/*
  register file storage array
  66 words of 64 bits with one synchronous write port and one registered
  read port, out-of-range writes are dropped and out-of-range reads give zero
*/

`timescale 1ns/100ps

`include "rf_settings.svh"

module rf_array
  import rf_pkg::*;
(
  input  logic       clock_b,
  input  rf_wr_req_t wr,
  input  rf_rd_req_t rd,
  output rf_data_t   rd_data
);

  // --------------------
  // storage
  // --------------------

  // the array itself carries no reset, its contents are undefined until written
  rf_data_t mem [`RF_ENTRIES];

  // registered read word that feeds the port control block
  rf_data_t rd_q;

  // address range decode for both ports
  logic wr_in_range;
  logic rd_in_range;

  // anything at or above the entry count has no word behind it
  assign wr_in_range = (wr.addr < `RF_ENTRIES);
  assign rd_in_range = (rd.addr < `RF_ENTRIES);

  // --------------------
  // write port
  // --------------------

  // the write lands on the rising edge when enabled and the address decodes
  // a write to an unused address is simply lost
  always_ff @(posedge clock_b)
  begin
    if (wr.en && wr_in_range)
    begin
      mem[wr.addr] <= wr.data;
    end
  end

  // --------------------
  // read port
  // --------------------

  // the read samples the array on the same edge as the write
  // since the write is non-blocking a same-address collision sees the old word
  // with the enable low the register keeps its last word
  always_ff @(posedge clock_b)
  begin
    if (rd.en)
    begin
      if (rd_in_range)
      begin
        rd_q <= mem[rd.addr];
      end
      else
      begin
        // out-of-range reads return an all zero word
        rd_q <= '0;
      end
    end
  end

  assign rd_data = rd_q;

endmodule

// File: hdl/rf_pkg.sv
/*
  register file package
  shared vector types and request structs for the two-port register file,
  plus the derived size of the folded observation word
*/

`include "rf_settings.svh"

package rf_pkg;

  // --------------------
  // derived sizes
  // --------------------

  // observed bits are write enable, write address, read enable and read address
  localparam int RF_OBS_PINS = 2 * `RF_ADDR_W + 2;

  // one flop per group of RF_OBS_XOR bits, and the last group takes what is left
  localparam int RF_OBS_FLOPS = (RF_OBS_PINS + `RF_OBS_XOR - 1) / `RF_OBS_XOR;

  // --------------------
  // plain vector types
  // --------------------

  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [`RF_WIDTH-1:0] rf_data_t;
  typedef logic [RF_OBS_FLOPS-1:0] rf_obs_t;

  // write request, 72 bits with the enable in the top bit
  typedef struct packed {
    logic     en;
    rf_addr_t addr;
    rf_data_t data;
  } rf_wr_req_t;

  // read request, 8 bits with the enable in the top bit
  typedef struct packed {
    logic     en;
    rf_addr_t addr;
  } rf_rd_req_t;

endpackage

// File: include/rf_settings.svh
/*
  register file settings
  sizing macros for the 66 entry by 64 bit two-port register file
  and its scan write-through observation flops
*/

`ifndef RF_SETTINGS_SVH
`define RF_SETTINGS_SVH

// number of words held by the array
`define RF_ENTRIES 66

// width of one stored word in bits
`define RF_WIDTH 64

// address width, enough for 66 entries
// addresses 66 to 127 decode to nothing and are treated as out of range
`define RF_ADDR_W 7

// number of observed control bits folded into a single XOR observation flop
`define RF_OBS_XOR 3

`endif
